//--- decode_trace.txt
# name inst pc rs1_data rs2_data | expected err funit rd_sel pc_sel op_a op_b imm rd_adr (hex)
add 002081b3 1000 10 20 0 1 2 0 10 20 0 3
addi_neg fff08293 1004 100 0 0 1 2 0 100 ffffffffffffffff ffffffffffffffff 5
addw 002083bb 1008 5 7 0 1 2 0 5 7 0 7
addiw 7ff0849b 100c 3 0 0 1 2 0 3 7ff 7ff 9
auipc 80000517 2000 0 0 0 1 2 0 2000 ffffffff80000000 ffffffff80000000 a
jal_neg 800000ef 3000 0 0 0 1 3 1 3000 fffffffffff00000 fffffffffff00000 1
jal_pos 001ff06f 3004 0 0 0 1 3 1 3004 ff800 ff800 0
beq_fwd 00208463 4000 0 0 0 1 0 2 4000 8 8 8
beq_back fe208ee3 4010 0 0 0 1 0 2 4010 fffffffffffffffc fffffffffffffffc 1d
lui 12345137 5000 0 0 0 0 1 0 0 0 12345000 2
jalr 010280e7 5004 8000 0 0 1 3 1 8000 10 10 1
ld_neg ff813303 6000 1000 0 0 2 2 0 ff8 0 fffffffffffffff8 6
sd 00713c23 6004 1000 deadbeef 0 2 0 0 1018 deadbeef 18 18
bad_7f 0000007f 7000 11 22 1 0 0 0 0 0 0 0
bad_ff 000000ff 7004 11 22 1 0 0 0 0 0 0 1
add_after 002081b3 7008 10 20 0 1 2 0 10 20 0 3

//--- src.f
+incdir+.
secv_pkg.sv
decoder.sv
imm_gen.sv
operand_mux.sv
decode_stage.sv
decode_assertions.sv
decode_checker.sv
tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_decode_stage
FILELIST  ?= src.f
LOG       ?= sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) secv_config.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST) decode_trace.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_decode_stage.sv
// Trace driven testbench for decode_stage; random idle gaps between lines, fixed seed 26

`timescale 1ns/10ps

`include "secv_config.svh"

module tb_decode_stage;

    localparam int MAX_GAP       = 3;       // Idle cycles are 0 to MAX_GAP-1
    localparam int DRAIN_TIMEOUT = 50;
    localparam int RUN_LIMIT     = 5000;    // Whole-run watchdog in cycles

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      valid_i;
    logic [`SECV_ILEN-1:0]     inst_i;
    logic [`SECV_XLEN-1:0]     pc_i;
    logic [`SECV_XLEN-1:0]     rs1_data_i;
    logic [`SECV_XLEN-1:0]     rs2_data_i;
    logic [`SECV_REG_AW-1:0]   rs1_adr_o;
    logic [`SECV_REG_AW-1:0]   rs2_adr_o;
    logic                      valid_o;
    logic                      err_o;
    logic [`SECV_XLEN-1:0]     op_a_o;
    logic [`SECV_XLEN-1:0]     op_b_o;
    logic [`SECV_XLEN-1:0]     imm_o;
    secv_pkg::funit_t          funit_o;
    secv_pkg::alu_op_sel_t     alu_op_sel_o;
    secv_pkg::rd_sel_t         rd_sel_o;
    secv_pkg::pc_sel_t         pc_sel_o;
    logic [`SECV_REG_AW-1:0]   rd_adr_o;
    logic [2:0]                funct3_o;

    int    fd;
    int    n;
    int    sent;
    int    gap;
    int    wait_cnt;
    int    tb_errors;
    int    total;
    string test_name;
    string header;
    logic [63:0] inst_v, pc_v, rs1_v, rs2_v;
    logic [63:0] expected [8];  // Expected columns belong to the checker

    int checker_checked;
    int checker_errors;

    decode_stage dut_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .rs1_adr_o    (rs1_adr_o),
        .rs2_adr_o    (rs2_adr_o),
        .valid_o      (valid_o),
        .err_o        (err_o),
        .op_a_o       (op_a_o),
        .op_b_o       (op_b_o),
        .imm_o        (imm_o),
        .funit_o      (funit_o),
        .alu_op_sel_o (alu_op_sel_o),
        .rd_sel_o     (rd_sel_o),
        .pc_sel_o     (pc_sel_o),
        .rd_adr_o     (rd_adr_o),
        .funct3_o     (funct3_o)
    );

    decode_checker u_checker (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_o),
        .err_i        (err_o),
        .funit_i      (funit_o),
        .alu_op_sel_i (alu_op_sel_o),
        .rd_sel_i     (rd_sel_o),
        .pc_sel_i     (pc_sel_o),
        .op_a_i       (op_a_o),
        .op_b_i       (op_b_o),
        .imm_i        (imm_o),
        .rd_adr_i     (rd_adr_o),
        .funct3_i     (funct3_o),
        .in_valid_i   (valid_i),
        .rs1_adr_i    (rs1_adr_o),
        .rs2_adr_i    (rs2_adr_o),
        .checked_o    (checker_checked),
        .errors_o     (checker_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Watchdog in case the main sequence gets stuck
    initial begin
        repeat (RUN_LIMIT) @(posedge clk_i);
        $display("Simulation did not finish within %0d cycles", RUN_LIMIT);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        sent       = 0;
        tb_errors  = 0;
        void'($urandom(26));

        fd = $fopen("decode_trace.txt", "r");
        if (fd == 0) begin
            $display("Testbench could not open the trace file");
            tb_errors++;
        end else begin
            void'($fgets(header, fd));
        end

        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        if (valid_o !== 1'b0) begin
            $display("valid_o is not low after reset");
            tb_errors++;
        end

        if (fd != 0) begin
            n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h\n", test_name,
                        inst_v, pc_v, rs1_v, rs2_v, expected[0], expected[1], expected[2],
                        expected[3], expected[4], expected[5], expected[6], expected[7]);
            while (n == 13) begin
                valid_i    <= 1'b1;
                inst_i     <= inst_v[31:0];
                pc_i       <= pc_v;
                rs1_data_i <= rs1_v;
                rs2_data_i <= rs2_v;
                sent++;
                gap = int'($urandom % MAX_GAP);
                @(posedge clk_i);
                if (gap > 0) begin
                    valid_i <= 1'b0;    // Idle gap
                    repeat (gap) @(posedge clk_i);
                end
                n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h\n", test_name,
                            inst_v, pc_v, rs1_v, rs2_v, expected[0], expected[1],
                            expected[2], expected[3], expected[4], expected[5],
                            expected[6], expected[7]);
            end
            valid_i <= 1'b0;
        end

        // Drain the last results
        wait_cnt = 0;
        while (checker_checked < sent && wait_cnt < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        if (checker_checked < sent) begin
            $display("Timed out waiting for results, %0d of %0d checked",
                     checker_checked, sent);
            tb_errors++;
        end
        repeat (2) @(posedge clk_i);

        total = tb_errors + checker_errors + dut_i.u_assertions.fail_count;
        $display("Errors: testbench %0d, checker %0d, assertions %0d, lines %0d",
                 tb_errors, checker_errors, dut_i.u_assertions.fail_count, sent);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- decode_checker.sv
// Compares each valid decode slot with the next trace line; samples on the falling clock edge

`timescale 1ns/10ps

`include "secv_config.svh"

module decode_checker (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic                      err_i,
    input  logic [1:0]                funit_i,
    input  logic                      alu_op_sel_i,
    input  logic [1:0]                rd_sel_i,
    input  logic [1:0]                pc_sel_i,
    input  logic [`SECV_XLEN-1:0]     op_a_i,
    input  logic [`SECV_XLEN-1:0]     op_b_i,
    input  logic [`SECV_XLEN-1:0]     imm_i,
    input  logic [`SECV_REG_AW-1:0]   rd_adr_i,
    input  logic [2:0]                funct3_i,
    input  logic                      in_valid_i,   // DUT input strobe
    input  logic [`SECV_REG_AW-1:0]   rs1_adr_i,
    input  logic [`SECV_REG_AW-1:0]   rs2_adr_i,
    output int                        checked_o,
    output int                        errors_o
);

    int    fd;
    int    n;
    int    open_err = 0;
    int    error_count = 0;
    int    check_count = 0;
    string test_name;
    string header;
    logic [63:0] inst, pc, rs1, rs2;    // Stimulus columns, inst gives the fields
    logic [63:0] exp_err, exp_funit, exp_rd_sel, exp_pc_sel;
    logic [63:0] exp_op_a, exp_op_b, exp_imm, exp_rd_adr;
    logic [2*`SECV_REG_AW-1:0] adr_q [$];   // rs1/rs2 addresses seen at issue
    logic [2*`SECV_REG_AW-1:0] adr_pair;

    assign checked_o = check_count;
    assign errors_o  = error_count + open_err;

    initial begin
        fd = $fopen("decode_trace.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open the trace file");
            open_err = 1;
        end else begin
            void'($fgets(header, fd));   // Column header line
        end
    end

    task automatic compare_value(input string field, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error %0s %0s expected %h actual %h", test_name, field, exp_v, act_v);
            error_count++;
        end
    endtask

    // Only the register and immediate ALU forms let the ALU decode funct3/funct7
    function automatic logic expected_alu_op_sel(input logic [6:0] opc);
        case (opc)
            secv_pkg::OPCODE_OP, secv_pkg::OPCODE_OP_32,
            secv_pkg::OPCODE_OP_IMM, secv_pkg::OPCODE_OP_IMM_32:
                return secv_pkg::ALU_OP_SEL_DECODER;
            default:
                return secv_pkg::ALU_OP_SEL_ADD;    // Target and link arithmetic
        endcase
    endfunction

    always @(negedge clk_i) begin
        if (rst_n_i && valid_i) begin
            n = 0;
            if (fd != 0) begin
                n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h\n", test_name,
                            inst, pc, rs1, rs2, exp_err, exp_funit, exp_rd_sel,
                            exp_pc_sel, exp_op_a, exp_op_b, exp_imm, exp_rd_adr);
            end
            if (n != 13) begin
                $display("DUT produced a valid result with no expected line left");
                error_count++;
            end else begin
                compare_value("err", exp_err, {63'b0, err_i});
                compare_value("funit", exp_funit, {62'b0, funit_i});
                compare_value("rd_sel", exp_rd_sel, {62'b0, rd_sel_i});
                compare_value("pc_sel", exp_pc_sel, {62'b0, pc_sel_i});
                compare_value("op_a", exp_op_a, op_a_i);
                compare_value("op_b", exp_op_b, op_b_i);
                compare_value("imm", exp_imm, imm_i);
                compare_value("rd_adr", exp_rd_adr, {59'b0, rd_adr_i});
                compare_value("funct3", {61'b0, inst[14:12]}, {61'b0, funct3_i});
                if (exp_funit == 64'(secv_pkg::FUNIT_ALU)) begin
                    compare_value("alu_op_sel", {63'b0, expected_alu_op_sel(inst[6:0])},
                                  {63'b0, alu_op_sel_i});
                end
                if (adr_q.size() == 0) begin
                    $display("No register addresses were seen for %0s", test_name);
                    error_count++;
                end else begin
                    adr_pair = adr_q.pop_front();
                    compare_value("rs1_adr", {59'b0, inst[19:15]}, {59'b0, adr_pair[9:5]});
                    compare_value("rs2_adr", {59'b0, inst[24:20]}, {59'b0, adr_pair[4:0]});
                end
                check_count++;
            end
        end
        if (rst_n_i && in_valid_i) begin
            adr_q.push_back({rs1_adr_i, rs2_adr_i});
        end
    end

endmodule

//--- decode_assertions.sv
// Bound into decode_stage; checks reset values, one-cycle valid latency and error suppression

`timescale 1ns/10ps

module decode_assertions (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  logic                  valid_o,
    input  logic                  err_o,
    input  secv_pkg::funit_t      funit_o,
    input  secv_pkg::rd_sel_t     rd_sel_o,
    input  secv_pkg::pc_sel_t     pc_sel_o
);

    int fail_count = 0;     // Read by the testbench at the end

    // Control part of the slot is idle while in reset
    reset_state: assert property (@(posedge clk_i)
        !rst_n_i |-> (!valid_o && !err_o && funit_o == secv_pkg::FUNIT_NONE &&
                      rd_sel_o == secv_pkg::RD_SEL_NONE &&
                      pc_sel_o == secv_pkg::PC_SEL_NXTPC))
    else begin
        fail_count++;
        $error("Control outputs not idle during reset");
    end

    valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ##1 (valid_o == $past(valid_i)))
    else begin
        fail_count++;
        $error("valid_o does not follow valid_i after one cycle");
    end

    // A bad instruction must have no side effects
    err_suppress: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && err_o) |-> (funit_o == secv_pkg::FUNIT_NONE &&
                                rd_sel_o == secv_pkg::RD_SEL_NONE &&
                                pc_sel_o == secv_pkg::PC_SEL_NXTPC))
    else begin
        fail_count++;
        $error("Error slot carries an active control word");
    end

endmodule

bind decode_stage decode_assertions u_assertions (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .valid_o  (valid_o),
    .err_o    (err_o),
    .funit_o  (funit_o),
    .rd_sel_o (rd_sel_o),
    .pc_sel_o (pc_sel_o)
);

//--- decode_stage.sv
// Decode stage top; register addresses leave combinationally, all other results one cycle later

`timescale 1ns/10ps

`include "secv_config.svh"

module decode_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic [`SECV_ILEN-1:0]     inst_i,
    input  logic [`SECV_XLEN-1:0]     pc_i,
    input  logic [`SECV_XLEN-1:0]     rs1_data_i,   // Same-cycle register file read
    input  logic [`SECV_XLEN-1:0]     rs2_data_i,
    output logic [`SECV_REG_AW-1:0]   rs1_adr_o,
    output logic [`SECV_REG_AW-1:0]   rs2_adr_o,
    output logic                      valid_o,
    output logic                      err_o,
    output logic [`SECV_XLEN-1:0]     op_a_o,
    output logic [`SECV_XLEN-1:0]     op_b_o,
    output logic [`SECV_XLEN-1:0]     imm_o,
    output secv_pkg::funit_t          funit_o,
    output secv_pkg::alu_op_sel_t     alu_op_sel_o,
    output secv_pkg::rd_sel_t         rd_sel_o,
    output secv_pkg::pc_sel_t         pc_sel_o,
    output logic [`SECV_REG_AW-1:0]   rd_adr_o,
    output logic [2:0]                funct3_o
);

    secv_pkg::funit_t      funit;
    secv_pkg::alu_op_sel_t alu_op_sel;
    secv_pkg::src1_sel_t   src1_sel;
    secv_pkg::src2_sel_t   src2_sel;
    secv_pkg::imm_sel_t    imm_sel;
    secv_pkg::rd_sel_t     rd_sel;
    secv_pkg::pc_sel_t     pc_sel;
    logic                  err;
    logic [`SECV_XLEN-1:0] imm;
    logic [`SECV_REG_AW-1:0] rd_adr;
    logic [2:0]            funct3;

    // Fixed RISC-V field positions
    assign rs1_adr_o = inst_i[19:15];
    assign rs2_adr_o = inst_i[24:20];
    assign rd_adr    = inst_i[11:7];
    assign funct3    = inst_i[14:12];

    decoder u_decoder (
        .inst_i       (inst_i),
        .opcode_o     (),           // Opcode not needed past decode
        .funit_o      (funit),
        .alu_op_sel_o (alu_op_sel),
        .src1_sel_o   (src1_sel),
        .src2_sel_o   (src2_sel),
        .imm_sel_o    (imm_sel),
        .rd_sel_o     (rd_sel),
        .pc_sel_o     (pc_sel),
        .err_o        (err)
    );

    imm_gen u_imm_gen (
        .inst_i    (inst_i),
        .imm_sel_i (imm_sel),
        .imm_o     (imm)
    );

    operand_mux u_operand_mux (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .imm_i        (imm),
        .src1_sel_i   (src1_sel),
        .src2_sel_i   (src2_sel),
        .funit_i      (funit),
        .alu_op_sel_i (alu_op_sel),
        .rd_sel_i     (rd_sel),
        .pc_sel_i     (pc_sel),
        .err_i        (err),
        .rd_adr_i     (rd_adr),
        .funct3_i     (funct3),
        .valid_o      (valid_o),
        .err_o        (err_o),
        .op_a_o       (op_a_o),
        .op_b_o       (op_b_o),
        .imm_o        (imm_o),
        .funit_o      (funit_o),
        .alu_op_sel_o (alu_op_sel_o),
        .rd_sel_o     (rd_sel_o),
        .pc_sel_o     (pc_sel_o),
        .rd_adr_o     (rd_adr_o),
        .funct3_o     (funct3_o)
    );

endmodule

//--- operand_mux.sv
// Operand select and decode/execute register; one-cycle latency, no stall, an error suppresses side effects

`timescale 1ns/10ps

`include "secv_config.svh"

module operand_mux (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic [`SECV_XLEN-1:0]     pc_i,
    input  logic [`SECV_XLEN-1:0]     rs1_data_i,
    input  logic [`SECV_XLEN-1:0]     rs2_data_i,
    input  logic [`SECV_XLEN-1:0]     imm_i,
    input  secv_pkg::src1_sel_t       src1_sel_i,
    input  secv_pkg::src2_sel_t       src2_sel_i,
    input  secv_pkg::funit_t          funit_i,
    input  secv_pkg::alu_op_sel_t     alu_op_sel_i,
    input  secv_pkg::rd_sel_t         rd_sel_i,
    input  secv_pkg::pc_sel_t         pc_sel_i,
    input  logic                      err_i,
    input  logic [`SECV_REG_AW-1:0]   rd_adr_i,
    input  logic [2:0]                funct3_i,
    output logic                      valid_o,
    output logic                      err_o,
    output logic [`SECV_XLEN-1:0]     op_a_o,
    output logic [`SECV_XLEN-1:0]     op_b_o,
    output logic [`SECV_XLEN-1:0]     imm_o,
    output secv_pkg::funit_t          funit_o,
    output secv_pkg::alu_op_sel_t     alu_op_sel_o,
    output secv_pkg::rd_sel_t         rd_sel_o,
    output secv_pkg::pc_sel_t         pc_sel_o,
    output logic [`SECV_REG_AW-1:0]   rd_adr_o,
    output logic [2:0]                funct3_o
);

    logic [`SECV_XLEN-1:0] op_a;
    logic [`SECV_XLEN-1:0] op_b;
    logic [`SECV_XLEN-1:0] mem_adr;

    assign mem_adr = rs1_data_i + imm_i;    // Load/store address adder

    always_comb begin
        case (src1_sel_i)
            secv_pkg::SRC1_SEL_PC:      op_a = pc_i;
            secv_pkg::SRC1_SEL_RS1:     op_a = rs1_data_i;
            secv_pkg::SRC1_SEL_RS1_IMM: op_a = mem_adr;
            default:                    op_a = '0;
        endcase

        case (src2_sel_i)
            secv_pkg::SRC2_SEL_RS2: op_b = rs2_data_i;
            secv_pkg::SRC2_SEL_IMM: op_b = imm_i;
            default:                op_b = '0;
        endcase
    end

    // Control part of the slot
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            err_o    <= 1'b0;
            funit_o  <= secv_pkg::FUNIT_NONE;
            rd_sel_o <= secv_pkg::RD_SEL_NONE;
            pc_sel_o <= secv_pkg::PC_SEL_NXTPC;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                err_o    <= err_i;
                // Bad instruction becomes a no-op
                funit_o  <= err_i ? secv_pkg::FUNIT_NONE   : funit_i;
                rd_sel_o <= err_i ? secv_pkg::RD_SEL_NONE  : rd_sel_i;
                pc_sel_o <= err_i ? secv_pkg::PC_SEL_NXTPC : pc_sel_i;
            end
        end
    end

    // Payload part, loaded with each valid instruction
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_a_o       <= op_a;
            op_b_o       <= op_b;
            imm_o        <= imm_i;
            alu_op_sel_o <= alu_op_sel_i;
            rd_adr_o     <= rd_adr_i;
            funct3_o     <= funct3_i;
        end
    end

endmodule

//--- imm_gen.sv
// Immediate generator for I, S, B, U and J formats, sign-extended to XLEN; unused selectors give zero

`timescale 1ns/10ps

`include "secv_config.svh"

module imm_gen (
    input  logic [`SECV_ILEN-1:0]  inst_i,
    input  secv_pkg::imm_sel_t     imm_sel_i,
    output logic [`SECV_XLEN-1:0]  imm_o
);

    logic sign;

    assign sign = inst_i[31];   // Sign bit sits at 31 in every format

    always_comb begin
        case (imm_sel_i)
            secv_pkg::IMM_SEL_I: imm_o = {{(`SECV_XLEN-12){sign}}, inst_i[31:20]};
            secv_pkg::IMM_SEL_S: imm_o = {{(`SECV_XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
            secv_pkg::IMM_SEL_B: begin
                // Branch offset, bit 0 always zero
                imm_o = {{(`SECV_XLEN-13){sign}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            end
            secv_pkg::IMM_SEL_U: imm_o = {{(`SECV_XLEN-32){sign}}, inst_i[31:12], 12'b0};
            secv_pkg::IMM_SEL_J: begin
                imm_o = {{(`SECV_XLEN-21){sign}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            end
            default: imm_o = '0;    // IMM_SEL_0 and unused codes
        endcase
    end

endmodule

//--- decoder.sv
// Control decoder for the listed RV64I opcodes only; funct3/funct7 are not checked here

`timescale 1ns/10ps

`include "secv_config.svh"

module decoder (
    input  logic [`SECV_ILEN-1:0]  inst_i,        // Instruction word
    output secv_pkg::opcode_t      opcode_o,
    output secv_pkg::funit_t       funit_o,       // Function unit
    output secv_pkg::alu_op_sel_t  alu_op_sel_o,
    output secv_pkg::src1_sel_t    src1_sel_o,
    output secv_pkg::src2_sel_t    src2_sel_o,
    output secv_pkg::imm_sel_t     imm_sel_o,     // Immediate format
    output secv_pkg::rd_sel_t      rd_sel_o,
    output secv_pkg::pc_sel_t      pc_sel_o,
    output logic                   err_o          // Unknown opcode
);

    secv_pkg::opcode_t opcode;

    assign opcode   = secv_pkg::opcode_t'(inst_i[6:0]);
    assign opcode_o = opcode;

    always_comb begin
        // Defaults describe a harmless no-op
        funit_o      = secv_pkg::FUNIT_NONE;
        alu_op_sel_o = secv_pkg::ALU_OP_SEL_DECODER;
        src1_sel_o   = secv_pkg::SRC1_SEL_0;
        src2_sel_o   = secv_pkg::SRC2_SEL_0;
        imm_sel_o    = secv_pkg::IMM_SEL_0;
        rd_sel_o     = secv_pkg::RD_SEL_NONE;
        pc_sel_o     = secv_pkg::PC_SEL_NXTPC;
        err_o        = 1'b0;

        unique case (opcode)
            secv_pkg::OPCODE_LUI: begin
                imm_sel_o = secv_pkg::IMM_SEL_U;
                rd_sel_o  = secv_pkg::RD_SEL_IMM;    // No unit, rd takes imm
            end
            secv_pkg::OPCODE_AUIPC: begin
                funit_o      = secv_pkg::FUNIT_ALU;
                alu_op_sel_o = secv_pkg::ALU_OP_SEL_ADD;
                src1_sel_o   = secv_pkg::SRC1_SEL_PC;
                src2_sel_o   = secv_pkg::SRC2_SEL_IMM;
                imm_sel_o    = secv_pkg::IMM_SEL_U;
                rd_sel_o     = secv_pkg::RD_SEL_FUNIT;
            end
            secv_pkg::OPCODE_JAL: begin
                funit_o      = secv_pkg::FUNIT_ALU;
                alu_op_sel_o = secv_pkg::ALU_OP_SEL_ADD;
                src1_sel_o   = secv_pkg::SRC1_SEL_PC;
                src2_sel_o   = secv_pkg::SRC2_SEL_IMM;
                imm_sel_o    = secv_pkg::IMM_SEL_J;
                rd_sel_o     = secv_pkg::RD_SEL_NXTPC;
                pc_sel_o     = secv_pkg::PC_SEL_FUNIT;   // Jump target from ALU
            end
            secv_pkg::OPCODE_JALR: begin
                funit_o      = secv_pkg::FUNIT_ALU;
                alu_op_sel_o = secv_pkg::ALU_OP_SEL_ADD;
                src1_sel_o   = secv_pkg::SRC1_SEL_RS1;
                src2_sel_o   = secv_pkg::SRC2_SEL_IMM;
                imm_sel_o    = secv_pkg::IMM_SEL_I;
                rd_sel_o     = secv_pkg::RD_SEL_NXTPC;
                pc_sel_o     = secv_pkg::PC_SEL_FUNIT;
            end
            secv_pkg::OPCODE_BRANCH: begin
                // Target computed here, condition resolved later
                funit_o      = secv_pkg::FUNIT_ALU;
                alu_op_sel_o = secv_pkg::ALU_OP_SEL_ADD;
                src1_sel_o   = secv_pkg::SRC1_SEL_PC;
                src2_sel_o   = secv_pkg::SRC2_SEL_IMM;
                imm_sel_o    = secv_pkg::IMM_SEL_B;
                pc_sel_o     = secv_pkg::PC_SEL_BRANCH;
            end
            secv_pkg::OPCODE_LOAD: begin
                funit_o    = secv_pkg::FUNIT_MEM;
                src1_sel_o = secv_pkg::SRC1_SEL_RS1_IMM;    // Address
                imm_sel_o  = secv_pkg::IMM_SEL_I;
                rd_sel_o   = secv_pkg::RD_SEL_FUNIT;
            end
            secv_pkg::OPCODE_STORE: begin
                funit_o    = secv_pkg::FUNIT_MEM;
                src1_sel_o = secv_pkg::SRC1_SEL_RS1_IMM;
                src2_sel_o = secv_pkg::SRC2_SEL_RS2;        // Store data
                imm_sel_o  = secv_pkg::IMM_SEL_S;
            end
            secv_pkg::OPCODE_OP, secv_pkg::OPCODE_OP_32: begin
                funit_o    = secv_pkg::FUNIT_ALU;
                src1_sel_o = secv_pkg::SRC1_SEL_RS1;
                src2_sel_o = secv_pkg::SRC2_SEL_RS2;
                rd_sel_o   = secv_pkg::RD_SEL_FUNIT;
            end
            secv_pkg::OPCODE_OP_IMM, secv_pkg::OPCODE_OP_IMM_32: begin
                funit_o    = secv_pkg::FUNIT_ALU;
                src1_sel_o = secv_pkg::SRC1_SEL_RS1;
                src2_sel_o = secv_pkg::SRC2_SEL_IMM;
                imm_sel_o  = secv_pkg::IMM_SEL_I;
                rd_sel_o   = secv_pkg::RD_SEL_FUNIT;
            end
            default: begin
                err_o = 1'b1;
            end
        endcase
    end

endmodule

//--- secv_pkg.sv
// Decode stage types; encodings of the selector enums are shared with the trace file

package secv_pkg;

    // RISC-V base opcodes known to the decoder
    typedef enum logic [6:0] {
        OPCODE_LUI       = 7'b0110111,
        OPCODE_AUIPC     = 7'b0010111,
        OPCODE_JAL       = 7'b1101111,
        OPCODE_JALR      = 7'b1100111,
        OPCODE_BRANCH    = 7'b1100011,
        OPCODE_LOAD      = 7'b0000011,
        OPCODE_STORE     = 7'b0100011,
        OPCODE_OP        = 7'b0110011,
        OPCODE_OP_32     = 7'b0111011,
        OPCODE_OP_IMM    = 7'b0010011,
        OPCODE_OP_IMM_32 = 7'b0011011
    } opcode_t;

    // Function unit that executes the instruction
    typedef enum logic [1:0] {
        FUNIT_NONE = 2'd0,
        FUNIT_ALU  = 2'd1,
        FUNIT_MEM  = 2'd2
    } funit_t;

    typedef enum logic {
        ALU_OP_SEL_ADD     = 1'b0,  // Force addition
        ALU_OP_SEL_DECODER = 1'b1   // ALU decodes funct3/funct7
    } alu_op_sel_t;

    // Operand A source
    typedef enum logic [1:0] {
        SRC1_SEL_0       = 2'd0,
        SRC1_SEL_PC      = 2'd1,
        SRC1_SEL_RS1     = 2'd2,
        SRC1_SEL_RS1_IMM = 2'd3    // Load/store address
    } src1_sel_t;

    // Operand B source
    typedef enum logic [1:0] {
        SRC2_SEL_0   = 2'd0,
        SRC2_SEL_RS2 = 2'd1,
        SRC2_SEL_IMM = 2'd2
    } src2_sel_t;

    // Immediate format
    typedef enum logic [2:0] {
        IMM_SEL_0 = 3'd0,
        IMM_SEL_I = 3'd1,
        IMM_SEL_S = 3'd2,
        IMM_SEL_B = 3'd3,
        IMM_SEL_U = 3'd4,
        IMM_SEL_J = 3'd5
    } imm_sel_t;

    // Write-back source for rd
    typedef enum logic [1:0] {
        RD_SEL_NONE  = 2'd0,
        RD_SEL_IMM   = 2'd1,
        RD_SEL_FUNIT = 2'd2,
        RD_SEL_NXTPC = 2'd3    // Link address
    } rd_sel_t;

    // Next pc source
    typedef enum logic [1:0] {
        PC_SEL_NXTPC  = 2'd0,
        PC_SEL_FUNIT  = 2'd1,
        PC_SEL_BRANCH = 2'd2
    } pc_sel_t;

endpackage

//--- secv_config.svh
// Architecture widths for the RV64I decode stage; XLEN must stay 64 and ILEN 32

`ifndef SECV_CONFIG_SVH
`define SECV_CONFIG_SVH

// Data path width, sizes pc, register data, immediate and operands
`define SECV_XLEN   64

`define SECV_ILEN   32  // Instruction width
`define SECV_REG_AW 5   // Register address width

`endif
